//--- color_tracker.f
+incdir+rtl
rtl/cam_types_pkg.sv
rtl/track_types_pkg.sv
rtl/serial_divider.sv
rtl/cam_capture.sv
rtl/pixel_locator.sv
rtl/color_threshold.sv
rtl/centroid_calc.sv
rtl/color_tracker.sv
test/color_tracker_tb.sv

//--- Makefile
TOP = color_tracker_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f color_tracker.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -f color_tracker.f --top-module color_tracker

clean:
	rm -rf obj_dir sim.log

//--- test/color_tracker_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tracker_consts.svh"

module color_tracker_tb;

  import cam_types_pkg::*;
  import track_types_pkg::*;

  localparam int frame_w     = 8;
  localparam int frame_h     = 4;
  localparam int n_rows      = 11;
  localparam int com_timeout = 2000;
  // launch, two 33-cycle divisions, update
  localparam int com_latency = 67;
  // sync flops plus the vsync edge register
  localparam int vsync_delay = `TRK_SYNC_STAGES + 1;

  logic         clk_65mhz;
  logic         sys_rst;
  cam_byte_t    cam_data;
  logic         cam_pclk;
  logic         cam_href;
  logic         cam_vsync;
  channel_sel_t channel_sel;
  intensity_t   lower_bound;
  intensity_t   upper_bound;
  hcount_t      x_com;
  vcount_t      y_com;
  logic         com_valid;

  // stimulus table with one frame per row
  string        row_name [n_rows];
  channel_sel_t row_ch   [n_rows];
  intensity_t   row_lb   [n_rows];
  intensity_t   row_ub   [n_rows];
  int           row_x0   [n_rows];
  int           row_y0   [n_rows];
  int           row_x1   [n_rows];
  int           row_y1   [n_rows];
  logic [15:0]  row_color[n_rows];
  bit           row_exp  [n_rows];

  // painted frame in line-major order
  logic [15:0]  frame_mem [frame_w * frame_h];

  integer seed;
  int     n_pass;
  int     n_fail;
  // last reported centroid that must hold over empty frames
  int     last_x;
  int     last_y;

  color_tracker u_color_tracker (
    .clk_65mhz   (clk_65mhz),
    .sys_rst     (sys_rst),
    .cam_data    (cam_data),
    .cam_pclk    (cam_pclk),
    .cam_href    (cam_href),
    .cam_vsync   (cam_vsync),
    .channel_sel (channel_sel),
    .lower_bound (lower_bound),
    .upper_bound (upper_bound),
    .x_com       (x_com),
    .y_com       (y_com),
    .com_valid   (com_valid)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever #10 clk_65mhz = ~clk_65mhz;
  end

  // rgb565 keeps red in 15:11, green in 10:5, blue in 4:0
  function automatic intensity_t chan_intensity(input logic [15:0] color,
                                                input channel_sel_t ch);
    case (ch)
      chan_red:   return color[15:12];
      chan_green: return color[10:7];
      default:    return color[4:1];
    endcase
  endfunction

  task automatic set_row(input int i, input string name, input channel_sel_t ch,
                         input intensity_t lb, input intensity_t ub,
                         input int x0, input int y0, input int x1, input int y1,
                         input logic [15:0] color, input bit exp_res);
    row_name[i]  = name;
    row_ch[i]    = ch;
    row_lb[i]    = lb;
    row_ub[i]    = ub;
    row_x0[i]    = x0;
    row_y0[i]    = y0;
    row_x1[i]    = x1;
    row_y1[i]    = y1;
    row_color[i] = color;
    row_exp[i]   = exp_res;
  endtask

  // random span inside 0..size-1
  task automatic rand_span(input int size, output int lo, output int hi);
    lo = $unsigned($random(seed)) % size;
    hi = lo + $unsigned($random(seed)) % (size - lo);
  endtask

  // inputs change just after the rising edge
  task automatic next_drive();
    @(posedge clk_65mhz);
    #2;
  endtask

  // one sensor clock of four system cycles with the byte set on the low half
  task automatic pclk_period(input cam_byte_t data, input logic href);
    next_drive();
    cam_data = data;
    cam_href = href;
    cam_pclk = 1'b0;
    next_drive();
    next_drive();
    cam_pclk = 1'b1;
    next_drive();
  endtask

  task automatic send_frame();
    int x;
    int y;
    int k;
    next_drive();
    cam_vsync = 1'b0;
    // idle sensor clocks before the first line
    for (k = 0; k < 4; k++) begin
      pclk_period(8'h00, 1'b0);
    end
    for (y = 0; y < frame_h; y++) begin
      for (x = 0; x < frame_w; x++) begin
        pclk_period(frame_mem[y * frame_w + x][15:8], 1'b1);
        pclk_period(frame_mem[y * frame_w + x][7:0], 1'b1);
      end
      // blanking keeps vsync low past the last byte
      pclk_period(8'h00, 1'b0);
      pclk_period(8'h00, 1'b0);
    end
  endtask

  // edges are counted from the cycle vsync was driven high
  task automatic wait_com_valid(output bit got, output int edges);
    got   = 1'b0;
    edges = 0;
    while (!got && edges < com_timeout) begin
      @(posedge clk_65mhz);
      edges++;
      @(negedge clk_65mhz);
      if (com_valid) begin
        got = 1'b1;
      end
    end
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input int exp_val, input int act_val);
    $display("Mismatch %s %s: expected %0d actual %0d", test, what, exp_val, act_val);
  endtask

  task automatic finish_test(input string test, input int errs);
    if (errs == 0) begin
      n_pass++;
      $display("ok      %s", test);
    end else begin
      n_fail++;
      $display("failed  %s (%0d errors)", test, errs);
    end
  endtask

  task automatic run_row(input int i);
    int  x;
    int  y;
    int  cnt;
    int  sx;
    int  sy;
    int  exp_x;
    int  exp_y;
    int  edges;
    int  errs;
    bit  got;
    intensity_t val;
    errs  = 0;
    cnt   = 0;
    sx    = 0;
    sy    = 0;
    exp_x = 0;
    exp_y = 0;
    // black frame with one rectangle
    for (y = 0; y < frame_h; y++) begin
      for (x = 0; x < frame_w; x++) begin
        if (x >= row_x0[i] && x <= row_x1[i] && y >= row_y0[i] && y <= row_y1[i]) begin
          frame_mem[y * frame_w + x] = row_color[i];
        end else begin
          frame_mem[y * frame_w + x] = 16'h0000;
        end
      end
    end
    // reference centroid as the floor of the masked mean
    for (y = 0; y < frame_h; y++) begin
      for (x = 0; x < frame_w; x++) begin
        val = chan_intensity(frame_mem[y * frame_w + x], row_ch[i]);
        if (val >= row_lb[i] && val <= row_ub[i]) begin
          cnt++;
          sx += x;
          sy += y;
        end
      end
    end
    if (cnt != 0) begin
      exp_x = sx / cnt;
      exp_y = sy / cnt;
    end
    next_drive();
    channel_sel = row_ch[i];
    lower_bound = row_lb[i];
    upper_bound = row_ub[i];
    send_frame();
    next_drive();
    cam_vsync = 1'b1;
    wait_com_valid(got, edges);
    if (row_exp[i]) begin
      if (!got) begin
        $display("Timeout: %s saw no com_valid within %0d cycles", row_name[i], com_timeout);
        errs++;
      end else begin
        if (int'(x_com) != exp_x) begin
          report_mismatch(row_name[i], "x_com", exp_x, int'(x_com));
          errs++;
        end
        if (int'(y_com) != exp_y) begin
          report_mismatch(row_name[i], "y_com", exp_y, int'(y_com));
          errs++;
        end
        if (edges - vsync_delay != com_latency) begin
          report_mismatch(row_name[i], "latency", com_latency, edges - vsync_delay);
          errs++;
        end
        last_x = exp_x;
        last_y = exp_y;
      end
    end else begin
      if (got) begin
        $display("%s raised com_valid for a frame with no masked pixel", row_name[i]);
        errs++;
      end
      // empty frame leaves the old centroid in place
      if (int'(x_com) != last_x) begin
        report_mismatch(row_name[i], "x_com hold", last_x, int'(x_com));
        errs++;
      end
      if (int'(y_com) != last_y) begin
        report_mismatch(row_name[i], "y_com hold", last_y, int'(y_com));
        errs++;
      end
    end
    finish_test(row_name[i], errs);
  endtask

  initial begin
    int r;
    int lo_x;
    int hi_x;
    int lo_y;
    int hi_y;
    int errs;
    seed        = 32'h8d89;
    n_pass      = 0;
    n_fail      = 0;
    last_x      = 0;
    last_y      = 0;
    sys_rst     = 1'b1;
    cam_data    = '0;
    cam_pclk    = 1'b0;
    cam_href    = 1'b0;
    cam_vsync   = 1'b0;
    channel_sel = chan_red;
    lower_bound = 4'd1;
    upper_bound = 4'd15;

    set_row(0, "single_px",     chan_red,   4'd8, 4'd15, 5, 2, 5, 2, 16'hf800, 1'b1);
    set_row(1, "rect_even",     chan_green, 4'd4, 4'd15, 2, 1, 5, 2, 16'h07e0, 1'b1);
    set_row(2, "rect_odd",      chan_blue,  4'd1, 4'd15, 1, 1, 3, 3, 16'h001f, 1'b1);
    set_row(3, "rect_floor",    chan_blue,  4'd1, 4'd15, 1, 0, 6, 3, 16'h001f, 1'b1);
    set_row(4, "chan_red",      chan_red,   4'd8, 4'd15, 3, 1, 7, 3, 16'hf800, 1'b1);
    // same frame where blue finds nothing
    set_row(5, "chan_blue",     chan_blue,  4'd1, 4'd15, 3, 1, 7, 3, 16'hf800, 1'b0);
    // red intensities 6, 9 and 10 against bounds 6..9
    set_row(6, "bound_low_eq",  chan_red,   4'd6, 4'd9,  0, 0, 2, 1, 16'h6000, 1'b1);
    set_row(7, "bound_high_eq", chan_red,   4'd6, 4'd9,  6, 2, 7, 3, 16'h9000, 1'b1);
    set_row(8, "bound_above",   chan_red,   4'd6, 4'd9,  0, 0, 7, 3, 16'ha000, 1'b0);
    for (r = 9; r < n_rows; r++) begin
      rand_span(frame_w, lo_x, hi_x);
      rand_span(frame_h, lo_y, hi_y);
      set_row(r, $sformatf("rand_%0d", r - 9), chan_green, 4'd8, 4'd15,
              lo_x, lo_y, hi_x, hi_y, 16'h07e0, 1'b1);
    end

    repeat (5) @(posedge clk_65mhz);
    #2;
    sys_rst = 1'b0;

    @(negedge clk_65mhz);
    errs = 0;
    if (com_valid !== 1'b0) begin
      report_mismatch("reset_state", "com_valid", 0, int'(com_valid));
      errs++;
    end
    if (x_com !== '0) begin
      report_mismatch("reset_state", "x_com", 0, int'(x_com));
      errs++;
    end
    if (y_com !== '0) begin
      report_mismatch("reset_state", "y_com", 0, int'(y_com));
      errs++;
    end
    finish_test("reset_state", errs);

    for (r = 0; r < n_rows; r++) begin
      run_row(r);
    end

    $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // backstop well beyond the longest run
  initial begin
    #5000000;
    $display("Simulation ran past its time limit");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/color_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module color_tracker (
  input  logic                          clk_65mhz,
  input  logic                          sys_rst,
  input  cam_types_pkg::cam_byte_t      cam_data,
  input  logic                          cam_pclk,
  input  logic                          cam_href,
  input  logic                          cam_vsync,
  input  track_types_pkg::channel_sel_t channel_sel,
  input  track_types_pkg::intensity_t   lower_bound,
  input  track_types_pkg::intensity_t   upper_bound,
  output cam_types_pkg::hcount_t        x_com,
  output cam_types_pkg::vcount_t        y_com,
  output logic                          com_valid
);

  import cam_types_pkg::*;

  // capture to locator
  pixel_t  pixel;
  logic    pixel_valid;
  logic    frame_done;
  logic    href_sync;
  // locator to threshold
  pixel_t  loc_pixel;
  hcount_t hcount;
  vcount_t vcount;
  logic    loc_valid;
  // threshold to centroid
  logic    mask;
  logic    mask_valid;
  hcount_t mask_x;
  vcount_t mask_y;

  cam_capture u_cam_capture (
    .clk_65mhz   (clk_65mhz),
    .sys_rst     (sys_rst),
    .cam_data    (cam_data),
    .cam_pclk    (cam_pclk),
    .cam_href    (cam_href),
    .cam_vsync   (cam_vsync),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .frame_done  (frame_done),
    .href_sync   (href_sync)
  );

  pixel_locator u_pixel_locator (
    .clk_65mhz   (clk_65mhz),
    .sys_rst     (sys_rst),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .frame_done  (frame_done),
    .href_sync   (href_sync),
    .loc_pixel   (loc_pixel),
    .hcount      (hcount),
    .vcount      (vcount),
    .loc_valid   (loc_valid)
  );

  color_threshold u_color_threshold (
    .clk_65mhz   (clk_65mhz),
    .sys_rst     (sys_rst),
    .loc_pixel   (loc_pixel),
    .hcount      (hcount),
    .vcount      (vcount),
    .loc_valid   (loc_valid),
    .channel_sel (channel_sel),
    .lower_bound (lower_bound),
    .upper_bound (upper_bound),
    .mask        (mask),
    .mask_valid  (mask_valid),
    .mask_x      (mask_x),
    .mask_y      (mask_y)
  );

  // frame_done goes straight across, the sums close on it
  centroid_calc u_centroid_calc (
    .clk_65mhz   (clk_65mhz),
    .sys_rst     (sys_rst),
    .mask        (mask),
    .mask_valid  (mask_valid),
    .mask_x      (mask_x),
    .mask_y      (mask_y),
    .frame_done  (frame_done),
    .x_com       (x_com),
    .y_com       (y_com),
    .com_valid   (com_valid)
  );

endmodule

`default_nettype wire

//--- rtl/centroid_calc.sv
`timescale 1ns/100ps
`default_nettype none

`include "tracker_consts.svh"

module centroid_calc (
  input  logic                   clk_65mhz,
  input  logic                   sys_rst,
  input  logic                   mask,
  input  logic                   mask_valid,
  input  cam_types_pkg::hcount_t mask_x,
  input  cam_types_pkg::vcount_t mask_y,
  input  logic                   frame_done,
  output cam_types_pkg::hcount_t x_com,
  output cam_types_pkg::vcount_t y_com,
  output logic                   com_valid
);

  import cam_types_pkg::*;
  import track_types_pkg::*;

  centroid_state_t state;
  // running totals for the current frame
  coord_sum_t      sum_x;
  coord_sum_t      sum_y;
  pix_count_t      count;
  // operands held for the y division
  coord_sum_t      sum_y_lat;
  pix_count_t      count_lat;
  // x result waits until y is done
  hcount_t         x_quot;

  logic            div_start;
  coord_sum_t      div_dividend;
  pix_count_t      div_divisor;
  coord_sum_t      div_quotient;
  logic            div_done;

  // x launches straight from the live sums, y chains off the x done
  assign div_start = (state == st_idle && frame_done && count != '0) ||
                     (state == st_div_x && div_done);
  assign div_dividend = (state == st_idle) ? sum_x : sum_y_lat;
  assign div_divisor  = (state == st_idle) ? count : count_lat;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state     <= st_idle;
      sum_x     <= '0;
      sum_y     <= '0;
      count     <= '0;
      x_com     <= '0;
      y_com     <= '0;
      com_valid <= 1'b0;
    end else begin
      com_valid <= 1'b0;
      if (frame_done) begin
        // new frame starts clean even when busy
        sum_x <= '0;
        sum_y <= '0;
        count <= '0;
      end else if (mask_valid && mask) begin
        sum_x <= sum_x + coord_sum_t'(mask_x);
        sum_y <= sum_y + coord_sum_t'(mask_y);
        count <= count + 1'b1;
      end
      case (state)
        st_idle: begin
          if (frame_done && count != '0) begin
            state <= st_div_x;
          end
        end
        st_div_x: begin
          if (div_done) begin
            state <= st_div_y;
          end
        end
        st_div_y: begin
          if (div_done) begin
            x_com     <= x_quot;
            y_com     <= div_quotient[`TRK_VCOUNT_W-1:0];
            com_valid <= 1'b1;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // operand and result holding
  always_ff @(posedge clk_65mhz) begin
    if (state == st_idle && frame_done) begin
      sum_y_lat <= sum_y;
      count_lat <= count;
    end
    if (state == st_div_x && div_done) begin
      x_quot <= div_quotient[`TRK_HCOUNT_W-1:0];
    end
  end

  serial_divider u_serial_divider (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (div_dividend),
    .divisor   (div_divisor),
    .quotient  (div_quotient),
    .done      (div_done)
  );

  // mean of in-frame coordinates never exceeds the counter range
  a_x_fits: assert property (
    @(posedge clk_65mhz) disable iff (sys_rst)
    (state == st_div_x && div_done) |-> (div_quotient[`TRK_SUM_W-1:`TRK_HCOUNT_W] == '0)
  );
  a_y_fits: assert property (
    @(posedge clk_65mhz) disable iff (sys_rst)
    (state == st_div_y && div_done) |-> (div_quotient[`TRK_SUM_W-1:`TRK_VCOUNT_W] == '0)
  );

endmodule

`default_nettype wire

//--- rtl/color_threshold.sv
`timescale 1ns/100ps
`default_nettype none

module color_threshold (
  input  logic                          clk_65mhz,
  input  logic                          sys_rst,
  input  cam_types_pkg::pixel_t         loc_pixel,
  input  cam_types_pkg::hcount_t        hcount,
  input  cam_types_pkg::vcount_t        vcount,
  input  logic                          loc_valid,
  input  track_types_pkg::channel_sel_t channel_sel,
  input  track_types_pkg::intensity_t   lower_bound,
  input  track_types_pkg::intensity_t   upper_bound,
  output logic                          mask,
  output logic                          mask_valid,
  output cam_types_pkg::hcount_t        mask_x,
  output cam_types_pkg::vcount_t        mask_y
);

  import track_types_pkg::*;

  intensity_t chan_val;
  logic       in_range;

  // top four bits of r5, g6 or b5
  always_comb begin
    case (channel_sel)
      chan_red:   chan_val = loc_pixel[15:12];
      chan_green: chan_val = loc_pixel[10:7];
      chan_blue:  chan_val = loc_pixel[4:1];
      default:    chan_val = '0;
    endcase
  end

  // both bounds inclusive
  assign in_range = (chan_val >= lower_bound) && (chan_val <= upper_bound);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      mask_valid <= 1'b0;
      mask       <= 1'b0;
    end else begin
      mask_valid <= loc_valid;
      mask       <= loc_valid & in_range;
    end
  end

  // coordinates ride along with the mask bit
  always_ff @(posedge clk_65mhz) begin
    if (loc_valid) begin
      mask_x <= hcount;
      mask_y <= vcount;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pixel_locator.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_locator (
  input  logic                   clk_65mhz,
  input  logic                   sys_rst,
  input  cam_types_pkg::pixel_t  pixel,
  input  logic                   pixel_valid,
  input  logic                   frame_done,
  input  logic                   href_sync,
  output cam_types_pkg::pixel_t  loc_pixel,
  output cam_types_pkg::hcount_t hcount,
  output cam_types_pkg::vcount_t vcount,
  output logic                   loc_valid
);

  import cam_types_pkg::*;

  // position of the next pixel to arrive
  hcount_t col_cnt;
  vcount_t line_cnt;
  logic    href_prev;
  // line saw at least one pixel
  logic    line_has_pix;
  logic    href_fall;

  assign href_fall = href_prev & ~href_sync;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      col_cnt      <= '0;
      line_cnt     <= '0;
      href_prev    <= 1'b0;
      line_has_pix <= 1'b0;
      loc_valid    <= 1'b0;
    end else begin
      href_prev <= href_sync;
      loc_valid <= pixel_valid;
      if (frame_done) begin
        col_cnt      <= '0;
        line_cnt     <= '0;
        line_has_pix <= 1'b0;
      end else if (href_fall) begin
        // empty href runs do not advance the line
        col_cnt      <= '0;
        line_has_pix <= 1'b0;
        if (line_has_pix || pixel_valid) begin
          line_cnt <= line_cnt + 1'b1;
        end
      end else if (pixel_valid) begin
        col_cnt      <= col_cnt + 1'b1;
        line_has_pix <= 1'b1;
      end
    end
  end

  // tag the pixel with where it landed
  always_ff @(posedge clk_65mhz) begin
    if (pixel_valid) begin
      loc_pixel <= pixel;
      hcount    <= col_cnt;
      vcount    <= line_cnt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cam_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "tracker_consts.svh"

module cam_capture (
  input  logic                   clk_65mhz,
  input  logic                   sys_rst,
  input  cam_types_pkg::cam_byte_t cam_data,
  input  logic                   cam_pclk,
  input  logic                   cam_href,
  input  logic                   cam_vsync,
  output cam_types_pkg::pixel_t  pixel,
  output logic                   pixel_valid,
  output logic                   frame_done,
  output logic                   href_sync
);

  import cam_types_pkg::*;

  // stage 0 samples the pin, last stage is safe to use
  logic [`TRK_SYNC_STAGES-1:0] pclk_chain;
  logic [`TRK_SYNC_STAGES-1:0] href_chain;
  logic [`TRK_SYNC_STAGES-1:0] vsync_chain;
  cam_byte_t                   data_chain [`TRK_SYNC_STAGES];

  logic      pclk_prev;
  logic      vsync_prev;
  logic      pclk_s;
  logic      vsync_s;
  logic      pclk_rise;
  cam_byte_t data_s;
  // set once the high byte of a pair is held
  logic      half_pixel;
  cam_byte_t high_byte;

  assign pclk_s    = pclk_chain[`TRK_SYNC_STAGES-1];
  assign vsync_s   = vsync_chain[`TRK_SYNC_STAGES-1];
  assign href_sync = href_chain[`TRK_SYNC_STAGES-1];
  assign data_s    = data_chain[`TRK_SYNC_STAGES-1];
  assign pclk_rise = pclk_s & ~pclk_prev;

  // control side of the synchronizers and the byte pairing
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pclk_chain  <= '0;
      href_chain  <= '0;
      vsync_chain <= '0;
      pclk_prev   <= 1'b0;
      vsync_prev  <= 1'b0;
      half_pixel  <= 1'b0;
      pixel_valid <= 1'b0;
      frame_done  <= 1'b0;
    end else begin
      pclk_chain  <= {pclk_chain[`TRK_SYNC_STAGES-2:0], cam_pclk};
      href_chain  <= {href_chain[`TRK_SYNC_STAGES-2:0], cam_href};
      vsync_chain <= {vsync_chain[`TRK_SYNC_STAGES-2:0], cam_vsync};
      pclk_prev   <= pclk_s;
      vsync_prev  <= vsync_s;
      // end of frame on the vsync rise
      frame_done  <= vsync_s & ~vsync_prev;
      pixel_valid <= 1'b0;
      if (!href_sync) begin
        // outside a line, drop any lone high byte
        half_pixel <= 1'b0;
      end else if (pclk_rise) begin
        half_pixel  <= ~half_pixel;
        pixel_valid <= half_pixel;
      end
    end
  end

  // data bus synchronizer
  always_ff @(posedge clk_65mhz) begin
    data_chain[0] <= cam_data;
    for (int i = 1; i < `TRK_SYNC_STAGES; i++) begin
      data_chain[i] <= data_chain[i-1];
    end
  end

  // high byte first, pixel formed on the low byte
  always_ff @(posedge clk_65mhz) begin
    if (href_sync && pclk_rise) begin
      if (half_pixel) begin
        pixel <= {high_byte, data_s};
      end else begin
        high_byte <= data_s;
      end
    end
  end

  // a pixel needs two sensor clocks, so valid is always isolated
  a_valid_single: assert property (
    @(posedge clk_65mhz) disable iff (sys_rst) pixel_valid |=> !pixel_valid
  );

endmodule

`default_nettype wire

//--- rtl/serial_divider.sv
`timescale 1ns/100ps
`default_nettype none

`include "tracker_consts.svh"

module serial_divider (
  input  logic                        clk_65mhz,
  input  logic                        sys_rst,
  input  logic                        start,
  input  track_types_pkg::coord_sum_t dividend,
  input  track_types_pkg::pix_count_t divisor,
  output track_types_pkg::coord_sum_t quotient,
  output logic                        done
);

  import track_types_pkg::*;

  // dividend bits shift out the top, quotient bits shift in the bottom
  coord_sum_t                acc;
  pix_count_t                rem;
  pix_count_t                div_reg;
  logic                      busy;
  logic [`TRK_DIV_CNT_W-1:0] bit_cnt;

  // one extra bit for the shifted partial remainder
  logic [`TRK_COUNT_W:0]     trial;
  logic [`TRK_COUNT_W:0]     diff;
  logic                      fits;

  assign quotient = acc;

  always_comb begin
    trial = {rem, acc[`TRK_SUM_W-1]};
    diff  = trial - {1'b0, div_reg};
    fits  = (trial >= {1'b0, div_reg});
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        // last of the 32 steps
        if (bit_cnt == {`TRK_DIV_CNT_W{1'b1}}) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // restoring step, subtract only when the divisor fits
  always_ff @(posedge clk_65mhz) begin
    if (start && !busy) begin
      acc     <= dividend;
      rem     <= '0;
      div_reg <= divisor;
    end else if (busy) begin
      acc <= {acc[`TRK_SUM_W-2:0], fits};
      if (fits) begin
        rem <= diff[`TRK_COUNT_W-1:0];
      end else begin
        rem <= trial[`TRK_COUNT_W-1:0];
      end
    end
  end

  // sequencer must wait for done before the next launch
  a_no_start_busy: assert property (
    @(posedge clk_65mhz) disable iff (sys_rst) busy |-> !start
  );

endmodule

`default_nettype wire

//--- rtl/track_types_pkg.sv
`default_nettype none

`include "tracker_consts.svh"

package track_types_pkg;

  // channel intensity, same width for the bounds
  typedef logic [`TRK_INTENSITY_W-1:0] intensity_t;

  // which rgb channel feeds the threshold
  typedef enum logic [1:0] {
    chan_red,
    chan_green,
    chan_blue
  } channel_sel_t;

  // running coordinate sums and division results
  typedef logic [`TRK_SUM_W-1:0]   coord_sum_t;
  // number of masked pixels in a frame
  typedef logic [`TRK_COUNT_W-1:0] pix_count_t;

  // centroid sequencer, x is divided first
  typedef enum logic [1:0] {
    st_idle,
    st_div_x,
    st_div_y
  } centroid_state_t;

endpackage

`default_nettype wire

//--- rtl/cam_types_pkg.sv
`default_nettype none

`include "tracker_consts.svh"

package cam_types_pkg;

  // raw byte from the sensor bus
  typedef logic [`TRK_BYTE_W-1:0]     cam_byte_t;
  // assembled pixel, red in the top five bits
  typedef logic [`TRK_PIXEL_W-1:0]    pixel_t;
  // position of a pixel inside the frame
  typedef logic [`TRK_HCOUNT_W-1:0]   hcount_t;
  typedef logic [`TRK_VCOUNT_W-1:0]   vcount_t;

endpackage

`default_nettype wire

//--- rtl/tracker_consts.svh
`ifndef TRACKER_CONSTS_SVH
`define TRACKER_CONSTS_SVH

// rgb565 pixel, two camera bytes
`define TRK_PIXEL_W      16
// camera parallel bus
`define TRK_BYTE_W       8
// pixel column and line counters
`define TRK_HCOUNT_W     11
`define TRK_VCOUNT_W     10
// top bits of one color channel
`define TRK_INTENSITY_W  4
// coordinate sums, also the divider dividend and quotient
`define TRK_SUM_W        32
// masked pixels per frame
`define TRK_COUNT_W      21
// flops per camera pin synchronizer
`define TRK_SYNC_STAGES  2
// divider bit counter, log2 of TRK_SUM_W
`define TRK_DIV_CNT_W    5

`endif
